// ==== include/flow_reasm_config.svh ====
`ifndef FLOW_REASM_CONFIG_SVH
`define FLOW_REASM_CONFIG_SVH

// Flow table
`define FR_FLOWS    4
`define FR_FLOW_W   2

// Node pool shared by all flows
`define FR_NODES    8
`define FR_NODE_W   3

// Segment fields
`define FR_SEQ_W    16
`define FR_LEN_W    8
`define FR_PKT_W    8

`endif

// ==== hdl/flow_reasm_pkg.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

package flow_reasm_pkg;

    // Incoming segment
    typedef struct packed {
        logic [`FR_FLOW_W-1:0]  flow;
        logic [`FR_SEQ_W-1:0]   seq;
        logic [`FR_LEN_W-1:0]   len;
        logic [`FR_PKT_W-1:0]   pkt_id;
    } seg_t;

    // Per-flow state
    typedef struct packed {
        logic [`FR_SEQ_W-1:0]   exp_seq;
        logic [`FR_NODE_W-1:0]  head;
        logic                   list_valid;
    } flow_entry_t;

    // Held out-of-order segment, linked in seq order
    typedef struct packed {
        logic [`FR_SEQ_W-1:0]   seq;
        logic [`FR_LEN_W-1:0]   len;
        logic [`FR_PKT_W-1:0]   pkt_id;
        logic [`FR_NODE_W-1:0]  next;
        logic                   last;
    } node_t;

    typedef enum logic [1:0] {
        REL_IN_ORDER,
        REL_REORDERED,
        REL_DROP
    } rel_kind_t;

    typedef struct packed {
        logic [`FR_PKT_W-1:0]   pkt_id;
        rel_kind_t              kind;
    } rel_t;

endpackage

`default_nettype wire

// ==== hdl/flow_table.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module flow_table (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [`FR_FLOW_W-1:0]        rd_flow,
    output flow_reasm_pkg::flow_entry_t  rd_entry,
    input  logic                         wr_en,
    input  logic [`FR_FLOW_W-1:0]        wr_flow,
    input  flow_reasm_pkg::flow_entry_t  wr_entry
);

flow_reasm_pkg::flow_entry_t entries [`FR_FLOWS];

assign rd_entry = entries[rd_flow];

// Every flow starts at seq 0 with no held segments
always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `FR_FLOWS; i++) begin
            entries[i] <= '0;
        end
    end
    else if (wr_en) begin
        entries[wr_flow] <= wr_entry;
    end
end

// Write-back must target the flow the controller was working on
wr_flow_matches_read: assert property (
    @(posedge clk) disable iff (rst)
    wr_en |-> (wr_flow == $past(rd_flow))
) else $error("flow_table: write-back to flow %0d, but flow %0d was read",
              wr_flow, $past(rd_flow));

endmodule

`default_nettype wire

// ==== hdl/node_store.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module node_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ins_start,
    input  logic [`FR_NODE_W-1:0]    ins_head,
    input  logic                     ins_list_valid,
    input  flow_reasm_pkg::node_t    ins_node,
    output logic                     ins_done,
    output logic                     ins_discard,
    output logic [`FR_NODE_W-1:0]    new_head,
    input  logic [`FR_NODE_W-1:0]    rd_ptr,
    output flow_reasm_pkg::node_t    rd_node,
    input  logic                     free_en,
    input  logic [`FR_NODE_W-1:0]    free_ptr
);

flow_reasm_pkg::node_t nodes [`FR_NODES];
logic [`FR_NODES-1:0]  free_map;

logic                  busy;
logic                  list_r;
logic                  has_free_r;
logic                  prev_valid;
logic [`FR_NODE_W-1:0] head_r;
logic [`FR_NODE_W-1:0] alloc_r;
logic [`FR_NODE_W-1:0] cur_ptr;
logic [`FR_NODE_W-1:0] prev_ptr;
flow_reasm_pkg::node_t new_r;
flow_reasm_pkg::node_t cur_node;
flow_reasm_pkg::node_t link_node;

logic                  any_free;
logic [`FR_NODE_W-1:0] free_idx;
logic                  before_cur;
logic                  do_discard;
logic                  do_link;
logic                  patch_en;
logic [`FR_NODE_W-1:0] patch_ptr;

assign cur_node = nodes[cur_ptr];
assign rd_node  = nodes[rd_ptr];

// Lowest free node
always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = `FR_NODES - 1; i >= 0; i--) begin
        if (free_map[i]) begin
            any_free = 1'b1;
            free_idx = `FR_NODE_W'(i);
        end
    end
end

// One list node is compared per cycle of the walk
assign before_cur = list_r && (cur_node.seq > new_r.seq);
assign do_discard = busy && (!has_free_r || (list_r && (cur_node.seq == new_r.seq)));
assign do_link    = busy && !do_discard && (!list_r || before_cur || cur_node.last);

// Predecessor to relink; none when the new node becomes the head
assign patch_en  = list_r && !(before_cur && !prev_valid);
assign patch_ptr = before_cur ? prev_ptr : cur_ptr;

always_comb begin
    link_node      = new_r;
    link_node.next = cur_ptr;
    link_node.last = !before_cur;
end

always_ff @(posedge clk) begin
    if (rst) begin
        busy     <= 1'b0;
        ins_done <= 1'b0;
        free_map <= '1;
    end
    else begin
        ins_done <= do_discard || do_link;
        if (ins_start && !busy) begin
            busy <= 1'b1;
        end
        else if (do_discard || do_link) begin
            busy <= 1'b0;
        end
        if (do_link) begin
            free_map[alloc_r] <= 1'b0;
        end
        if (free_en) begin
            free_map[free_ptr] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (ins_start && !busy) begin
        new_r      <= ins_node;
        head_r     <= ins_head;
        list_r     <= ins_list_valid;
        has_free_r <= any_free;
        alloc_r    <= free_idx;
        cur_ptr    <= ins_head;
        prev_valid <= 1'b0;
    end
    else if (busy && !do_discard && !do_link) begin
        prev_ptr   <= cur_ptr;
        prev_valid <= 1'b1;
        cur_ptr    <= cur_node.next;
    end
    if (do_discard || do_link) begin
        ins_discard <= do_discard;
        new_head    <= patch_en ? head_r : alloc_r;
    end
    if (do_link) begin
        nodes[alloc_r] <= link_node;
        if (patch_en) begin
            nodes[patch_ptr].next <= alloc_r;
            nodes[patch_ptr].last <= 1'b0;
        end
    end
end

// A request during a walk would be ignored
ins_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    ins_start |-> !busy
) else $error("node_store: insertion requested while a walk is running");

// A released node must have been allocated by an earlier insertion
free_of_used_node: assert property (
    @(posedge clk) disable iff (rst)
    free_en |-> !free_map[free_ptr]
) else $error("node_store: free of node %0d, which is already free", free_ptr);

endmodule

`default_nettype wire

// ==== hdl/reasm_ctrl.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module reasm_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         seg_valid,
    input  flow_reasm_pkg::seg_t         seg,
    output logic                         ready,
    input  logic                         out_almost_full,
    output logic                         rel_valid,
    output flow_reasm_pkg::rel_t         rel,
    output logic [`FR_FLOW_W-1:0]        rd_flow,
    input  flow_reasm_pkg::flow_entry_t  rd_entry,
    output logic                         wr_en,
    output logic [`FR_FLOW_W-1:0]        wr_flow,
    output flow_reasm_pkg::flow_entry_t  wr_entry,
    output logic                         ins_start,
    output logic [`FR_NODE_W-1:0]        ins_head,
    output logic                         ins_list_valid,
    output flow_reasm_pkg::node_t        ins_node,
    input  logic                         ins_done,
    input  logic                         ins_discard,
    input  logic [`FR_NODE_W-1:0]        new_head,
    output logic [`FR_NODE_W-1:0]        rd_ptr,
    input  flow_reasm_pkg::node_t        rd_node,
    output logic                         free_en,
    output logic [`FR_NODE_W-1:0]        free_ptr
);

typedef enum logic [2:0] {
    S_IDLE,
    S_COMPARE,
    S_INS_WAIT,
    S_CHAIN,
    S_WRBACK
} state_t;

state_t                      state;
flow_reasm_pkg::seg_t        cur_seg;
flow_reasm_pkg::flow_entry_t cur_entry;
logic                        walk_gap;
logic [`FR_SEQ_W-1:0]        seg_end;
logic [`FR_SEQ_W-1:0]        node_end;
logic                        chain_hit;
logic                        chain_go;

assign ready   = (state == S_IDLE) && !out_almost_full;
assign rd_flow = (state == S_IDLE) ? seg.flow : cur_seg.flow;

assign seg_end  = cur_seg.seq + `FR_SEQ_W'(cur_seg.len);
assign node_end = rd_node.seq + `FR_SEQ_W'(rd_node.len);

// List head is due for release, either matching or stale
assign rd_ptr    = cur_entry.head;
assign chain_hit = cur_entry.list_valid && (rd_node.seq <= cur_entry.exp_seq);
assign chain_go  = (state == S_CHAIN) && chain_hit && !walk_gap && !out_almost_full;

assign free_en  = chain_go;
assign free_ptr = cur_entry.head;

assign ins_head       = cur_entry.head;
assign ins_list_valid = cur_entry.list_valid;

always_comb begin
    ins_node.seq    = cur_seg.seq;
    ins_node.len    = cur_seg.len;
    ins_node.pkt_id = cur_seg.pkt_id;
    ins_node.next   = '0;
    ins_node.last   = 1'b1;
end

assign wr_en    = (state == S_WRBACK);
assign wr_flow  = cur_seg.flow;
assign wr_entry = cur_entry;

always_ff @(posedge clk) begin
    if (rst) begin
        state     <= S_IDLE;
        rel_valid <= 1'b0;
        ins_start <= 1'b0;
        walk_gap  <= 1'b0;
    end
    else begin
        rel_valid <= 1'b0;
        ins_start <= 1'b0;
        case (state)
            S_IDLE: begin
                if (seg_valid && ready) begin
                    cur_seg   <= seg;
                    cur_entry <= rd_entry;
                    state     <= S_COMPARE;
                end
            end
            S_COMPARE: begin
                rel.pkt_id <= cur_seg.pkt_id;
                if (cur_seg.seq == cur_entry.exp_seq) begin
                    rel_valid         <= 1'b1;
                    rel.kind          <= flow_reasm_pkg::REL_IN_ORDER;
                    cur_entry.exp_seq <= seg_end;
                    walk_gap          <= 1'b1;
                    state <= cur_entry.list_valid ? S_CHAIN : S_WRBACK;
                end
                else if (cur_seg.seq > cur_entry.exp_seq) begin
                    ins_start <= 1'b1;
                    state     <= S_INS_WAIT;
                end
                else begin
                    rel_valid <= 1'b1;
                    rel.kind  <= flow_reasm_pkg::REL_DROP;
                    state     <= S_WRBACK;
                end
            end
            S_INS_WAIT: begin
                if (ins_done) begin
                    if (ins_discard) begin
                        rel_valid <= 1'b1;
                        rel.kind  <= flow_reasm_pkg::REL_DROP;
                    end
                    else begin
                        cur_entry.head       <= new_head;
                        cur_entry.list_valid <= 1'b1;
                    end
                    state <= S_WRBACK;
                end
            end
            S_CHAIN: begin
                // One idle cycle between releases, longer under back-pressure
                walk_gap <= 1'b0;
                if (!chain_hit) begin
                    state <= S_WRBACK;
                end
                else if (chain_go) begin
                    rel_valid  <= 1'b1;
                    rel.pkt_id <= rd_node.pkt_id;
                    if (rd_node.seq == cur_entry.exp_seq) begin
                        rel.kind          <= flow_reasm_pkg::REL_REORDERED;
                        cur_entry.exp_seq <= node_end;
                    end
                    else begin
                        rel.kind <= flow_reasm_pkg::REL_DROP;
                    end
                    cur_entry.head       <= rd_node.next;
                    cur_entry.list_valid <= !rd_node.last;
                    walk_gap             <= 1'b1;
                end
            end
            S_WRBACK: begin
                state <= S_IDLE;
            end
            default: begin
                state <= S_IDLE;
            end
        endcase
    end
end

seg_only_when_ready: assert property (
    @(posedge clk) disable iff (rst)
    seg_valid |-> ready
) else $error("reasm_ctrl: segment offered while ready is low");

endmodule

`default_nettype wire

// ==== hdl/flow_reassembly.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module flow_reassembly (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  seg_valid,
    input  flow_reasm_pkg::seg_t  seg,
    output logic                  ready,
    input  logic                  out_almost_full,
    output logic                  rel_valid,
    output flow_reasm_pkg::rel_t  rel
);

logic [`FR_FLOW_W-1:0]       rd_flow;
flow_reasm_pkg::flow_entry_t rd_entry;
logic                        wr_en;
logic [`FR_FLOW_W-1:0]       wr_flow;
flow_reasm_pkg::flow_entry_t wr_entry;

logic                        ins_start;
logic [`FR_NODE_W-1:0]       ins_head;
logic                        ins_list_valid;
flow_reasm_pkg::node_t       ins_node;
logic                        ins_done;
logic                        ins_discard;
logic [`FR_NODE_W-1:0]       new_head;
logic [`FR_NODE_W-1:0]       rd_ptr;
flow_reasm_pkg::node_t       rd_node;
logic                        free_en;
logic [`FR_NODE_W-1:0]       free_ptr;

flow_table u_flow_table (
    .clk      (clk),
    .rst      (rst),
    .rd_flow  (rd_flow),
    .rd_entry (rd_entry),
    .wr_en    (wr_en),
    .wr_flow  (wr_flow),
    .wr_entry (wr_entry)
);

node_store u_node_store (
    .clk            (clk),
    .rst            (rst),
    .ins_start      (ins_start),
    .ins_head       (ins_head),
    .ins_list_valid (ins_list_valid),
    .ins_node       (ins_node),
    .ins_done       (ins_done),
    .ins_discard    (ins_discard),
    .new_head       (new_head),
    .rd_ptr         (rd_ptr),
    .rd_node        (rd_node),
    .free_en        (free_en),
    .free_ptr       (free_ptr)
);

reasm_ctrl u_reasm_ctrl (
    .clk             (clk),
    .rst             (rst),
    .seg_valid       (seg_valid),
    .seg             (seg),
    .ready           (ready),
    .out_almost_full (out_almost_full),
    .rel_valid       (rel_valid),
    .rel             (rel),
    .rd_flow         (rd_flow),
    .rd_entry        (rd_entry),
    .wr_en           (wr_en),
    .wr_flow         (wr_flow),
    .wr_entry        (wr_entry),
    .ins_start       (ins_start),
    .ins_head        (ins_head),
    .ins_list_valid  (ins_list_valid),
    .ins_node        (ins_node),
    .ins_done        (ins_done),
    .ins_discard     (ins_discard),
    .new_head        (new_head),
    .rd_ptr          (rd_ptr),
    .rd_node         (rd_node),
    .free_en         (free_en),
    .free_ptr        (free_ptr)
);

endmodule

`default_nettype wire

// ==== dv/reasm_checker.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module reasm_checker (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             seg_valid,
    input  flow_reasm_pkg::seg_t             seg,
    input  logic                             ready,
    input  logic                             out_almost_full,
    input  logic                             rel_valid,
    input  flow_reasm_pkg::rel_t             rel,
    output int                               error_count,
    output int                               pending,
    output logic [`FR_FLOWS*`FR_SEQ_W-1:0]   exp_view
);

// Stream edge per flow, and a pool of held segments shared by all flows
logic [`FR_SEQ_W-1:0]  exp_seq [`FR_FLOWS];
logic                  m_used [`FR_NODES];
logic [`FR_FLOW_W-1:0] m_flow [`FR_NODES];
logic [`FR_SEQ_W-1:0]  m_seq [`FR_NODES];
logic [`FR_LEN_W-1:0]  m_len [`FR_NODES];
logic [`FR_PKT_W-1:0]  m_pkt [`FR_NODES];

flow_reasm_pkg::rel_t  exp_q [$];
logic                  chain_q [$];
logic                  af_prev;

// Lowest held seq of a flow, -1 when the flow holds nothing
function automatic int head_of(input logic [`FR_FLOW_W-1:0] f);
    int h;
    h = -1;
    for (int i = 0; i < `FR_NODES; i++) begin
        if (m_used[i] && m_flow[i] == f) begin
            if (h < 0) begin
                h = i;
            end
            else if (m_seq[i] < m_seq[h]) begin
                h = i;
            end
        end
    end
    return h;
endfunction

task automatic expect_release(input logic [`FR_PKT_W-1:0] pkt,
                              input flow_reasm_pkg::rel_kind_t kind,
                              input logic from_chain);
    flow_reasm_pkg::rel_t item;
    item.pkt_id = pkt;
    item.kind   = kind;
    exp_q.push_back(item);
    chain_q.push_back(from_chain);
endtask

task automatic model_segment(input flow_reasm_pkg::seg_t s);
    int   h;
    int   slot;
    logic dup;
    slot = -1;
    dup  = 1'b0;
    if (s.seq == exp_seq[s.flow]) begin
        expect_release(s.pkt_id, flow_reasm_pkg::REL_IN_ORDER, 1'b0);
        exp_seq[s.flow] = exp_seq[s.flow] + `FR_SEQ_W'(s.len);
        h = head_of(s.flow);
        while (h >= 0 && m_seq[h] <= exp_seq[s.flow]) begin
            if (m_seq[h] == exp_seq[s.flow]) begin
                expect_release(m_pkt[h], flow_reasm_pkg::REL_REORDERED, 1'b1);
                exp_seq[s.flow] = exp_seq[s.flow] + `FR_SEQ_W'(m_len[h]);
            end
            else begin
                expect_release(m_pkt[h], flow_reasm_pkg::REL_DROP, 1'b1);
            end
            m_used[h] = 1'b0;
            h = head_of(s.flow);
        end
    end
    else if (s.seq > exp_seq[s.flow]) begin
        for (int i = `FR_NODES - 1; i >= 0; i--) begin
            if (!m_used[i]) begin
                slot = i;
            end
            else if (m_flow[i] == s.flow && m_seq[i] == s.seq) begin
                dup = 1'b1;
            end
        end
        if (slot < 0 || dup) begin
            expect_release(s.pkt_id, flow_reasm_pkg::REL_DROP, 1'b0);
        end
        else begin
            m_used[slot] = 1'b1;
            m_flow[slot] = s.flow;
            m_seq[slot]  = s.seq;
            m_len[slot]  = s.len;
            m_pkt[slot]  = s.pkt_id;
        end
    end
    else begin
        expect_release(s.pkt_id, flow_reasm_pkg::REL_DROP, 1'b0);
    end
endtask

task automatic check_release();
    flow_reasm_pkg::rel_t want;
    logic                 was_chain;
    if (exp_q.size() == 0) begin
        $display("error: at %0t a release of packet %0d came with none pending",
                 $time, rel.pkt_id);
        error_count++;
    end
    else begin
        want      = exp_q.pop_front();
        was_chain = chain_q.pop_front();
        if (rel.pkt_id !== want.pkt_id) begin
            $display("error: time %0t rel.pkt_id is %0d, expected %0d",
                     $time, rel.pkt_id, want.pkt_id);
            error_count++;
        end
        if (rel.kind !== want.kind) begin
            $display("error: time %0t rel.kind is %0d, expected %0d",
                     $time, rel.kind, want.kind);
            error_count++;
        end
        if (was_chain && af_prev) begin
            $display("error: at %0t a chain release started while almost full was high",
                     $time);
            error_count++;
        end
    end
endtask

always @(posedge clk) begin
    if (rst) begin
        for (int f = 0; f < `FR_FLOWS; f++) begin
            exp_seq[f] = '0;
        end
        for (int i = 0; i < `FR_NODES; i++) begin
            m_used[i] = 1'b0;
        end
        exp_q.delete();
        chain_q.delete();
        error_count = 0;
        af_prev     = 1'b0;
    end
    else begin
        if (ready && out_almost_full) begin
            $display("error: at %0t ready was high while almost full was high", $time);
            error_count++;
        end
        if (seg_valid && ready) begin
            // All releases of the previous segment come before ready rises
            if (exp_q.size() != 0) begin
                $display("error: at %0t a segment was accepted with %0d releases outstanding",
                         $time, exp_q.size());
                error_count++;
            end
            model_segment(seg);
        end
        if (rel_valid) begin
            check_release();
        end
        af_prev = out_almost_full;
    end
    pending = exp_q.size();
    for (int f = 0; f < `FR_FLOWS; f++) begin
        exp_view[f*`FR_SEQ_W +: `FR_SEQ_W] = exp_seq[f];
    end
end

endmodule

`default_nettype wire

// ==== dv/tb_flow_reassembly.sv ====
`default_nettype none

`include "flow_reasm_config.svh"

module tb_flow_reassembly;

localparam int NUM_SEGS   = 400;
localparam int WAIT_LIMIT = 200;

logic                           clk;
logic                           rst;
logic                           seg_valid;
flow_reasm_pkg::seg_t           seg;
logic                           ready;
logic                           out_almost_full;
logic                           rel_valid;
flow_reasm_pkg::rel_t           rel;

int                             error_count;
int                             pending;
logic [`FR_FLOWS*`FR_SEQ_W-1:0] exp_view;

logic [31:0]                    lcg_state;
int                             timeouts;
// Open gap per flow and the end of the data already sent past it
logic [`FR_LEN_W-1:0]           gap_len [`FR_FLOWS];
logic [`FR_SEQ_W-1:0]           ahead [`FR_FLOWS];

flow_reassembly dut (
    .clk             (clk),
    .rst             (rst),
    .seg_valid       (seg_valid),
    .seg             (seg),
    .ready           (ready),
    .out_almost_full (out_almost_full),
    .rel_valid       (rel_valid),
    .rel             (rel)
);

reasm_checker chk (
    .clk             (clk),
    .rst             (rst),
    .seg_valid       (seg_valid),
    .seg             (seg),
    .ready           (ready),
    .out_almost_full (out_almost_full),
    .rel_valid       (rel_valid),
    .rel             (rel),
    .error_count     (error_count),
    .pending         (pending),
    .exp_view        (exp_view)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic int rand_below(input int n);
    return int'((lcg_next() >> 8) % n);
endfunction

// Checks ready before touching almost full, so the two never race
task automatic wait_for_ready(output logic ok);
    int n;
    n = 0;
    while (!ready && n < WAIT_LIMIT) begin
        out_almost_full = (rand_below(4) == 0);
        @(negedge clk);
        n++;
    end
    ok = ready;
endtask

task automatic make_segment(input int idx);
    logic [`FR_FLOW_W-1:0] f;
    logic [`FR_SEQ_W-1:0]  e;
    int                    pick;
    f    = `FR_FLOW_W'(rand_below(`FR_FLOWS));
    pick = rand_below(16);
    e    = exp_view[f*`FR_SEQ_W +: `FR_SEQ_W];
    seg.flow   = f;
    seg.pkt_id = `FR_PKT_W'(idx);
    seg.len    = `FR_LEN_W'(1 + rand_below(16));
    if (pick < 6) begin
        // At the stream edge, mostly closing the open gap exactly
        seg.seq = e;
        if (gap_len[f] != 0 && pick < 5) begin
            seg.len = gap_len[f];
        end
        gap_len[f] = '0;
    end
    else if (pick < 12) begin
        if (gap_len[f] == 0) begin
            gap_len[f] = `FR_LEN_W'(1 + rand_below(16));
            ahead[f]   = e + `FR_SEQ_W'(gap_len[f]);
        end
        seg.seq  = ahead[f];
        ahead[f] = ahead[f] + `FR_SEQ_W'(seg.len);
    end
    else if (pick < 13) begin
        // Same seq as the first segment held past the gap
        seg.seq = e + `FR_SEQ_W'(gap_len[f]);
    end
    else if (pick < 14) begin
        seg.seq = e + `FR_SEQ_W'(17 + rand_below(32));
    end
    else begin
        // Stale, but never below seq 0
        seg.seq = (e == 0) ? e : e - `FR_SEQ_W'(1 + rand_below((e < 8) ? int'(e) : 8));
    end
endtask

initial begin
    logic ok;
    rst             = 1'b1;
    seg_valid       = 1'b0;
    seg             = '0;
    out_almost_full = 1'b0;
    lcg_state       = 32'h6f31_52e5;
    timeouts        = 0;
    for (int f = 0; f < `FR_FLOWS; f++) begin
        gap_len[f] = '0;
        ahead[f]   = '0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < NUM_SEGS && timeouts == 0; i++) begin
        wait_for_ready(ok);
        if (!ok) begin
            $display("timeout: ready stayed low for %0d cycles before segment %0d",
                     WAIT_LIMIT, i);
            timeouts++;
        end
        else begin
            make_segment(i);
            seg_valid = 1'b1;
            @(negedge clk);
            seg_valid = 1'b0;
        end
    end

    // Last segment finishes once ready is back
    if (timeouts == 0) begin
        wait_for_ready(ok);
        if (!ok) begin
            $display("timeout: ready stayed low for %0d cycles after the last segment",
                     WAIT_LIMIT);
            timeouts++;
        end
    end
    if (pending != 0) begin
        $display("error: %0d expected releases never arrived", pending);
    end

    $display("errors: %0d release checks, %0d missing releases, %0d timeouts",
             error_count, pending, timeouts);
    if (error_count == 0 && pending == 0 && timeouts == 0) begin
        $display("PASS: all tests");
    end
    else begin
        $display("FAIL: see errors above");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
hdl/flow_reasm_pkg.sv
hdl/flow_table.sv
hdl/node_store.sv
hdl/reasm_ctrl.sv
hdl/flow_reassembly.sv
dv/reasm_checker.sv
dv/tb_flow_reassembly.sv

// ==== Bender.yml ====
package:
  name: flow_reassembly

export_include_dirs:
  - include

sources:
  - hdl/flow_reasm_pkg.sv
  - hdl/flow_table.sv
  - hdl/node_store.sv
  - hdl/reasm_ctrl.sv
  - hdl/flow_reassembly.sv
  - target: test
    files:
      - dv/reasm_checker.sv
      - dv/tb_flow_reassembly.sv
